// ==== common/shell_cfg_pkg.sv ====
//==========================================================================
// Shell configuration definitions
// Command opcodes, option bits, keyboard scan codes and button positions
//==========================================================================
package shell_cfg_pkg;

	// Command port opcodes
	typedef enum logic [1:0] {
		OP_NOP           = 2'd0,
		OP_SET_OPTIONS   = 2'd1,
		OP_CORE_RESET    = 2'd2,
		OP_CLEAR_OPTIONS = 2'd3
	} shell_op_e;

	// Option byte layout
	localparam int OPT_ROTATE       = 0;
	localparam int OPT_SCANLINES_LO = 1;
	localparam int OPT_SCANLINES_HI = 2;

	// PS/2 set 2 make codes the cabinet understands
	typedef enum logic [7:0] {
		KEY_UP     = 8'h75,
		KEY_DOWN   = 8'h72,
		KEY_LEFT   = 8'h6B,
		KEY_RIGHT  = 8'h74,
		KEY_COIN   = 8'h76, // Esc
		KEY_START1 = 8'h05, // F1
		KEY_START2 = 8'h06, // F2
		KEY_FIRE2  = 8'h11, // Alt
		KEY_FIRE1  = 8'h29  // Space
	} key_code_e;

	// Positions in the keyboard button vector
	localparam int NUM_BUTTONS = 9;
	localparam int BTN_UP      = 0;
	localparam int BTN_DOWN    = 1;
	localparam int BTN_LEFT    = 2;
	localparam int BTN_RIGHT   = 3;
	localparam int BTN_FIRE1   = 4;
	localparam int BTN_FIRE2   = 5;
	localparam int BTN_START1  = 6;
	localparam int BTN_START2  = 7;
	localparam int BTN_COIN    = 8;

	// Joystick word bits
	localparam int JOY_RIGHT = 0;
	localparam int JOY_LEFT  = 1;
	localparam int JOY_DOWN  = 2;
	localparam int JOY_UP    = 3;
	localparam int JOY_FIRE1 = 4;
	localparam int JOY_FIRE2 = 5;

endpackage

// ==== common/video_pkg.sv ====
//==========================================================================
// Video path definitions
// Core colour depth and scanline dimming levels
//==========================================================================
package video_pkg;

	// Per-channel colour width delivered by the game core
	localparam int COLOR_BITS = 4;

	// Brightness of odd lines
	typedef enum logic [1:0] {
		SCAN_OFF = 2'd0, // Full brightness
		SCAN_25  = 2'd1, // Three quarters
		SCAN_50  = 2'd2, // Half
		SCAN_75  = 2'd3  // One quarter
	} scan_level_e;

endpackage

// ==== hdl/core_control.sv ====
//==========================================================================
// Core control
// Option register loaded from the command port, core reset sequencing
//==========================================================================
`timescale 1ns/1ps

module core_control
	import shell_cfg_pkg::*, video_pkg::*;
#(
	parameter int RESET_HOLD = 16
) (
	input  logic        clk_sys,
	input  logic        arst_n,
	input  logic        cfg_strobe,
	input  shell_op_e   cfg_op,
	input  logic [7:0]  cfg_data,
	input  logic        reset_button,
	output logic        rotate,
	output scan_level_e scan_level,
	output logic        core_reset
);

	localparam int HOLD_W = $clog2((RESET_HOLD > 1) ? RESET_HOLD : 2);
	localparam logic [HOLD_W-1:0] HOLD_LOAD = HOLD_W'(RESET_HOLD - 1);

	typedef enum logic {
		CTL_RESET,
		CTL_RUN
	} ctl_state_e;

	ctl_state_e        state;
	logic [HOLD_W-1:0] hold_cnt;
	logic              restart;

	// Any cause that (re)starts the hold-down period
	assign restart = reset_button | (cfg_strobe && (cfg_op == OP_CORE_RESET));

	//======================================================================
	// Option register
	//======================================================================
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			rotate     <= 1'b0;
			scan_level <= SCAN_OFF;
		end else if (cfg_strobe) begin
			case (cfg_op)
				OP_SET_OPTIONS: begin
					rotate     <= cfg_data[OPT_ROTATE];
					scan_level <= scan_level_e'(cfg_data[OPT_SCANLINES_HI:OPT_SCANLINES_LO]);
				end
				OP_CLEAR_OPTIONS: begin
					rotate     <= 1'b0;
					scan_level <= SCAN_OFF;
				end
				default: ; // NOP and reset leave options alone
			endcase
		end
	end

	//======================================================================
	// Reset sequencer
	//======================================================================
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			state    <= CTL_RESET;
			hold_cnt <= HOLD_LOAD;
		end else if (restart) begin
			state    <= CTL_RESET; // Button held keeps reloading
			hold_cnt <= HOLD_LOAD;
		end else begin
			case (state)
				CTL_RESET: begin
					if (hold_cnt == '0)
						state <= CTL_RUN;
					else
						hold_cnt <= hold_cnt - 1'b1;
				end
				default: ;
			endcase
		end
	end

	assign core_reset = (state == CTL_RESET);

endmodule

// ==== hdl/clock_enables.sv ====
//==========================================================================
// Clock enables
// 12 MHz, two-phase 6 MHz and sound strobes derived from clk_sys
//==========================================================================
`timescale 1ns/1ps

module clock_enables #(
	parameter int SOUND_DIV = 14
) (
	input  logic clk_sys,
	input  logic arst_n,
	output logic ce_12,
	output logic ce_6p,
	output logic ce_6n,
	output logic ce_sound
);

	localparam int SND_W = $clog2((SOUND_DIV > 1) ? SOUND_DIV : 2);
	localparam logic [SND_W-1:0] SND_LOAD = SND_W'(SOUND_DIV - 1);

	logic [1:0]       phase;
	logic [SND_W-1:0] snd_cnt;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			phase    <= 2'd0;
			snd_cnt  <= SND_LOAD;
			ce_12    <= 1'b0;
			ce_6p    <= 1'b0;
			ce_6n    <= 1'b0;
			ce_sound <= 1'b0;
		end else begin
			phase <= phase + 2'd1;
			ce_12 <= phase[0];
			ce_6p <= phase[0] & ~phase[1]; // Phase 1
			ce_6n <= phase[0] &  phase[1]; // Phase 3, two cycles later
			// Sound divider
			ce_sound <= (snd_cnt == '0);
			snd_cnt  <= (snd_cnt == '0) ? SND_LOAD : snd_cnt - 1'b1;
		end
	end

endmodule

// ==== hdl/key_decoder.sv ====
//==========================================================================
// Keyboard decoder
// Tracks pressed state of each cabinet key from scan code strobes
//==========================================================================
`timescale 1ns/1ps

module key_decoder
	import shell_cfg_pkg::*;
(
	input  logic                   clk_sys,
	input  logic                   arst_n,
	input  logic                   key_strobe,
	input  logic                   key_pressed,
	input  logic [7:0]             key_code,
	output logic [NUM_BUTTONS-1:0] key_buttons
);

	key_code_e code;

	assign code = key_code_e'(key_code);

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			key_buttons <= '0;
		end else if (key_strobe) begin
			case (code)
				KEY_UP:     key_buttons[BTN_UP]     <= key_pressed;
				KEY_DOWN:   key_buttons[BTN_DOWN]   <= key_pressed;
				KEY_LEFT:   key_buttons[BTN_LEFT]   <= key_pressed;
				KEY_RIGHT:  key_buttons[BTN_RIGHT]  <= key_pressed;
				KEY_COIN:   key_buttons[BTN_COIN]   <= key_pressed;
				KEY_START1: key_buttons[BTN_START1] <= key_pressed;
				KEY_START2: key_buttons[BTN_START2] <= key_pressed;
				KEY_FIRE2:  key_buttons[BTN_FIRE2]  <= key_pressed;
				KEY_FIRE1:  key_buttons[BTN_FIRE1]  <= key_pressed;
				default: ; // Other keys are of no interest
			endcase
		end
	end

endmodule

// ==== hdl/control_mapper.sv ====
//==========================================================================
// Control mapper
// Merges keyboard and joysticks, rotates directions, active-low outputs
//==========================================================================
`timescale 1ns/1ps

module control_mapper
	import shell_cfg_pkg::*;
(
	input  logic                   clk_sys,
	input  logic                   arst_n,
	input  logic                   rotate,
	input  logic [NUM_BUTTONS-1:0] key_buttons,
	input  logic [7:0]             joystick_0,
	input  logic [7:0]             joystick_1,
	output logic [6:0]             ip_1p,
	output logic [6:0]             ip_2p,
	output logic                   ip_coin1
);

	logic [7:0] key_joy; // Keyboard in joystick layout
	logic [7:0] ctl_1p;

	// Player word {start, fire2, fire1, left, right, up, down}, active high
	function automatic logic [6:0] map_player(input logic rot, input logic start,
	                                          input logic [7:0] ctl);
		logic up, down, left, right;
		up    = rot ? ctl[JOY_LEFT]  : ctl[JOY_UP];
		down  = rot ? ctl[JOY_RIGHT] : ctl[JOY_DOWN];
		left  = rot ? ctl[JOY_DOWN]  : ctl[JOY_LEFT];
		right = rot ? ctl[JOY_UP]    : ctl[JOY_RIGHT];
		return {start, ctl[JOY_FIRE2], ctl[JOY_FIRE1], left, right, up, down};
	endfunction

	always_comb begin
		key_joy            = '0;
		key_joy[JOY_UP]    = key_buttons[BTN_UP];
		key_joy[JOY_DOWN]  = key_buttons[BTN_DOWN];
		key_joy[JOY_LEFT]  = key_buttons[BTN_LEFT];
		key_joy[JOY_RIGHT] = key_buttons[BTN_RIGHT];
		key_joy[JOY_FIRE1] = key_buttons[BTN_FIRE1];
		key_joy[JOY_FIRE2] = key_buttons[BTN_FIRE2];
	end

	assign ctl_1p = key_joy | joystick_0;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			ip_1p    <= '1; // Nothing pressed
			ip_2p    <= '1;
			ip_coin1 <= 1'b1;
		end else begin
			ip_1p    <= ~map_player(rotate, key_buttons[BTN_START1], ctl_1p);
			ip_2p    <= ~map_player(rotate, key_buttons[BTN_START2], joystick_1);
			ip_coin1 <= ~key_buttons[BTN_COIN];
		end
	end

endmodule

// ==== hdl/video_blanker.sv ====
//==========================================================================
// Video blanker
// Blank gating, sync inversion and scanline dimming on odd lines
//==========================================================================
`timescale 1ns/1ps

module video_blanker
	import video_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  arst_n,
	input  scan_level_e           scan_level,
	input  logic [COLOR_BITS-1:0] core_r,
	input  logic [COLOR_BITS-1:0] core_g,
	input  logic [COLOR_BITS-1:0] core_b,
	input  logic                  core_hs,
	input  logic                  core_vs,
	input  logic                  core_hb,
	input  logic                  core_vb,
	output logic [COLOR_BITS-1:0] vga_r,
	output logic [COLOR_BITS-1:0] vga_g,
	output logic [COLOR_BITS-1:0] vga_b,
	output logic                  vga_hs,
	output logic                  vga_vs
);

	logic hs_q, vs_q;
	logic line_odd, line_odd_cur;
	logic blank;

	// Scale one channel, rounding down
	function automatic logic [COLOR_BITS-1:0] shade(input logic [COLOR_BITS-1:0] c,
	                                                input scan_level_e lvl, input logic dim);
		logic [COLOR_BITS+1:0] c3;
		logic [COLOR_BITS-1:0] res;
		c3 = {2'b00, c} + {1'b0, c, 1'b0}; // 3 * c
		case (lvl)
			SCAN_25: res = c3[COLOR_BITS+1:2];
			SCAN_50: res = c >> 1;
			SCAN_75: res = c >> 2;
			default: res = c;
		endcase
		return dim ? res : c;
	endfunction

	assign blank = core_hb | core_vb;

	// Parity of the line this sample belongs to
	always_comb begin
		line_odd_cur = line_odd;
		if (core_vs & ~vs_q)
			line_odd_cur = 1'b0; // Frame start
		else if (core_hs & ~hs_q)
			line_odd_cur = ~line_odd;
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			hs_q     <= 1'b0;
			vs_q     <= 1'b0;
			line_odd <= 1'b0;
			vga_r    <= '0;
			vga_g    <= '0;
			vga_b    <= '0;
			vga_hs   <= 1'b1;
			vga_vs   <= 1'b1;
		end else begin
			hs_q     <= core_hs;
			vs_q     <= core_vs;
			line_odd <= line_odd_cur;
			vga_hs   <= ~core_hs;
			vga_vs   <= ~core_vs;
			vga_r    <= blank ? '0 : shade(core_r, scan_level, line_odd_cur);
			vga_g    <= blank ? '0 : shade(core_g, scan_level, line_odd_cur);
			vga_b    <= blank ? '0 : shade(core_b, scan_level, line_odd_cur);
		end
	end

endmodule

// ==== hdl/sigma_delta_dac.sv ====
//==========================================================================
// Sigma-delta DAC
// First-order one-bit modulator for the core's audio word
//==========================================================================
`timescale 1ns/1ps

module sigma_delta_dac #(
	parameter int DAC_WIDTH = 10
) (
	input  logic                 clk_sys,
	input  logic                 arst_n,
	input  logic [DAC_WIDTH-1:0] dac_in,
	output logic                 dac_out
);

	logic [DAC_WIDTH:0] acc; // Top bit is the carry out

	// Residue plus new sample, carry becomes the output bit
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n)
			acc <= '0;
		else
			acc <= {1'b0, acc[DAC_WIDTH-1:0]} + {1'b0, dac_in};
	end

	assign dac_out = acc[DAC_WIDTH];

endmodule

// ==== hdl/arcade_shell.sv ====
//==========================================================================
// Arcade shell top level
// Board-side glue between the game core, controls, display and audio
//==========================================================================
`timescale 1ns/1ps

module arcade_shell
	import shell_cfg_pkg::*, video_pkg::*;
#(
	parameter int SOUND_DIV  = 14,
	parameter int DAC_WIDTH  = 10,
	parameter int RESET_HOLD = 16
) (
	input  logic                  clk_sys,
	input  logic                  arst_n,
	// Command port
	input  logic                  cfg_strobe,
	input  shell_op_e             cfg_op,
	input  logic [7:0]            cfg_data,
	// Keyboard and controls
	input  logic                  key_strobe,
	input  logic                  key_pressed,
	input  logic [7:0]            key_code,
	input  logic [7:0]            joystick_0,
	input  logic [7:0]            joystick_1,
	input  logic                  reset_button,
	// From the core
	input  logic [COLOR_BITS-1:0] core_r,
	input  logic [COLOR_BITS-1:0] core_g,
	input  logic [COLOR_BITS-1:0] core_b,
	input  logic                  core_hs,
	input  logic                  core_vs,
	input  logic                  core_hb,
	input  logic                  core_vb,
	input  logic [DAC_WIDTH-1:0]  core_audio,
	// To the core
	output logic [6:0]            ip_1p,
	output logic [6:0]            ip_2p,
	output logic                  ip_coin1,
	output logic                  core_reset,
	output logic                  ce_12,
	output logic                  ce_6p,
	output logic                  ce_6n,
	output logic                  ce_sound,
	// Display and audio
	output logic [COLOR_BITS-1:0] vga_r,
	output logic [COLOR_BITS-1:0] vga_g,
	output logic [COLOR_BITS-1:0] vga_b,
	output logic                  vga_hs,
	output logic                  vga_vs,
	output logic                  audio_l,
	output logic                  audio_r
);

	logic                   rotate;
	scan_level_e            scan_level;
	logic [NUM_BUTTONS-1:0] key_buttons;
	logic                   dac_out;

	core_control #(.RESET_HOLD(RESET_HOLD)) core_control_i (
		.clk_sys, .arst_n, .cfg_strobe, .cfg_op, .cfg_data, .reset_button,
		.rotate, .scan_level, .core_reset
	);

	clock_enables #(.SOUND_DIV(SOUND_DIV)) clock_enables_i (
		.clk_sys, .arst_n, .ce_12, .ce_6p, .ce_6n, .ce_sound
	);

	key_decoder key_decoder_i (
		.clk_sys, .arst_n, .key_strobe, .key_pressed, .key_code, .key_buttons
	);

	control_mapper control_mapper_i (
		.clk_sys, .arst_n, .rotate, .key_buttons, .joystick_0, .joystick_1,
		.ip_1p, .ip_2p, .ip_coin1
	);

	video_blanker video_blanker_i (
		.clk_sys, .arst_n, .scan_level,
		.core_r, .core_g, .core_b, .core_hs, .core_vs, .core_hb, .core_vb,
		.vga_r, .vga_g, .vga_b, .vga_hs, .vga_vs
	);

	sigma_delta_dac #(.DAC_WIDTH(DAC_WIDTH)) sigma_delta_dac_i (
		.clk_sys, .arst_n, .dac_in(core_audio), .dac_out
	);

	assign audio_l = dac_out; // Mono stream on both channels
	assign audio_r = dac_out;

endmodule

// ==== testbench/arcade_shell_checker.sv ====
//==========================================================================
// Arcade shell checker
// Concurrent assertions on the clock enables and the core reset
//==========================================================================
`timescale 1ns/1ps

module arcade_shell_checker
	import shell_cfg_pkg::*;
(
	input logic      clk_sys,
	input logic      arst_n,
	input logic      ce_12,
	input logic      ce_6p,
	input logic      ce_6n,
	input logic      cfg_strobe,
	input shell_op_e cfg_op,
	input logic      core_reset
);

	// The two 6 MHz phases never overlap
	a_ce6_exclusive: assert property (@(posedge clk_sys) disable iff (!arst_n)
		!(ce_6p && ce_6n))
		else $error("ce_6p and ce_6n high in the same cycle");

	a_ce6p_on_ce12: assert property (@(posedge clk_sys) disable iff (!arst_n)
		ce_6p |-> ce_12)
		else $error("ce_6p high without ce_12");

	// Reset command holds the core on the very next cycle
	a_core_reset_cmd: assert property (@(posedge clk_sys) disable iff (!arst_n)
		(cfg_strobe && (cfg_op == OP_CORE_RESET)) |=> core_reset)
		else $error("core_reset low after a core reset command");

endmodule

bind arcade_shell arcade_shell_checker arcade_shell_checker_i (
	.clk_sys(clk_sys), .arst_n(arst_n), .ce_12(ce_12), .ce_6p(ce_6p), .ce_6n(ce_6n),
	.cfg_strobe(cfg_strobe), .cfg_op(cfg_op), .core_reset(core_reset)
);

// ==== testbench/arcade_shell_tb.sv ====
//==========================================================================
// Arcade shell testbench
// Drives the shell from the stimulus file and checks every response
//==========================================================================
`timescale 1ns/1ps

module arcade_shell_tb
	import shell_cfg_pkg::*, video_pkg::*;
();

	localparam int SOUND_DIV  = 14;
	localparam int DAC_WIDTH  = 10;
	localparam int RESET_HOLD = 16;
	localparam int HOLD_LIMIT = 4 * RESET_HOLD; // Stuck reset after this many cycles

	logic                  clk_sys;
	logic                  arst_n;
	logic                  cfg_strobe;
	shell_op_e             cfg_op;
	logic [7:0]            cfg_data;
	logic                  key_strobe;
	logic                  key_pressed;
	logic [7:0]            key_code;
	logic [7:0]            joystick_0;
	logic [7:0]            joystick_1;
	logic                  reset_button;
	logic [COLOR_BITS-1:0] core_r, core_g, core_b;
	logic                  core_hs, core_vs, core_hb, core_vb;
	logic [DAC_WIDTH-1:0]  core_audio;
	logic [6:0]            ip_1p, ip_2p;
	logic                  ip_coin1, core_reset;
	logic                  ce_12, ce_6p, ce_6n, ce_sound;
	logic [COLOR_BITS-1:0] vga_r, vga_g, vga_b;
	logic                  vga_hs, vga_vs, audio_l, audio_r;

	logic [7:0]  kb_joy; // Held keys in joystick layout
	logic        kb_start1, kb_start2;
	logic        opt_rotate;
	logic [31:0] lcg_state;

	arcade_shell #(
		.SOUND_DIV(SOUND_DIV), .DAC_WIDTH(DAC_WIDTH), .RESET_HOLD(RESET_HOLD)
	) arcade_shell_i (.*);

	initial clk_sys = 1'b0;
	always #50 clk_sys = ~clk_sys; // 100 ns period

	//======================================================================
	// Helpers
	//======================================================================
	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Active-low {start, fire2, fire1, left, right, up, down}
	function automatic logic [6:0] expected_word(input logic rot, input logic start,
	                                             input logic [7:0] ctl);
		logic [6:0] w;
		w[6] = start;
		w[5] = ctl[JOY_FIRE2];
		w[4] = ctl[JOY_FIRE1];
		w[3] = rot ? ctl[JOY_DOWN]  : ctl[JOY_LEFT];
		w[2] = rot ? ctl[JOY_UP]    : ctl[JOY_RIGHT];
		w[1] = rot ? ctl[JOY_LEFT]  : ctl[JOY_UP];
		w[0] = rot ? ctl[JOY_RIGHT] : ctl[JOY_DOWN];
		return ~w;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1, "run aborted");
	endtask

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
	                           input string name);
		if (got !== exp) begin
			$display("FAIL at %0t: %s is %0h, expected %0h", $time, name, got, exp);
			$display("Test failed");
			$fatal(1, "value mismatch");
		end
	endtask

	// Counts falling-edge samples with core_reset high from the current edge on
	task automatic measure_reset_hold(input string cause);
		int held;
		held = 0;
		while (core_reset) begin
			held++;
			if (held > HOLD_LIMIT)
				abort_run($sformatf("core_reset never dropped after %s", cause));
			@(negedge clk_sys);
		end
		check_value(32'(held), 32'(RESET_HOLD), "core_reset hold cycles");
	endtask

	//======================================================================
	// Stimulus
	//======================================================================
	initial begin
		int               fd, rc, nf, i;
		int               n12, n6p, n6n, nsnd, nrst, last_snd, ones, level;
		logic [7:0]       rec;
		logic [31:0]      fld [12];
		logic [8*128-1:0] line_buf;
		bit               done;
		arst_n       = 1'b0;
		cfg_strobe   = 1'b0;
		cfg_op       = OP_NOP;
		cfg_data     = 8'h00;
		key_strobe   = 1'b0;
		key_pressed  = 1'b0;
		key_code     = 8'h00;
		joystick_0   = 8'h00;
		joystick_1   = 8'h00;
		reset_button = 1'b0;
		core_r       = '0;
		core_g       = '0;
		core_b       = '0;
		core_hs      = 1'b0;
		core_vs      = 1'b0;
		core_hb      = 1'b0;
		core_vb      = 1'b0;
		core_audio   = '0;
		kb_joy       = 8'h00;
		kb_start1    = 1'b0;
		kb_start2    = 1'b0;
		opt_rotate   = 1'b0;
		lcg_state    = 32'hb13a;

		// Release reset, then count enables over 56 cycles
		repeat (10) @(negedge clk_sys);
		arst_n   = 1'b1;
		nrst     = core_reset ? 1 : 0; // Sample at the release edge counts
		n12      = 0;
		n6p      = 0;
		n6n      = 0;
		nsnd     = 0;
		last_snd = 0;
		for (i = 1; i <= 56; i++) begin
			@(negedge clk_sys);
			if (ce_12) n12++;
			if (ce_6p) n6p++;
			if (ce_6n) n6n++;
			if (core_reset) nrst++;
			if (ce_sound) begin
				nsnd++;
				if (last_snd != 0)
					check_value(32'(i - last_snd), 32'(SOUND_DIV), "ce_sound spacing");
				last_snd = i;
			end
		end
		check_value(32'(n12), 32'd28, "ce_12 count");
		check_value(32'(n6p), 32'd14, "ce_6p count");
		check_value(32'(n6n), 32'd14, "ce_6n count");
		check_value(32'(nsnd), 32'd4, "ce_sound count");
		check_value(32'(nrst), 32'(RESET_HOLD), "core_reset after release");

		// Reset button held for a while
		reset_button = 1'b1;
		repeat (5) @(negedge clk_sys);
		reset_button = 1'b0;
		measure_reset_hold("reset_button");

		fd = $fopen("testbench/arcade_shell_stim.txt", "r");
		if (fd == 0)
			abort_run("cannot open testbench/arcade_shell_stim.txt");
		done = 1'b0;
		while (!done) begin
			rc = $fscanf(fd, " %c", rec);
			if (rc != 1) begin
				done = 1'b1;
			end else if (rec == "#") begin
				rc = $fgets(line_buf, fd); // Skip comment line
			end else begin
				nf = 0;
				case (rec)
					"K", "C": nf = 2;
					"E":      nf = 3;
					"J", "A": nf = 1;
					"V":      nf = 12;
					default:  abort_run($sformatf("unknown record type %c in stimulus", rec));
				endcase
				for (i = 0; i < nf; i++) begin
					rc = $fscanf(fd, " %h", fld[i]);
					if (rc != 1)
						abort_run($sformatf("record %c in stimulus is missing fields", rec));
				end
				case (rec)
					"K": begin
						key_pressed = fld[0][0];
						key_code    = fld[1][7:0];
						key_strobe  = 1'b1;
						@(negedge clk_sys);
						key_strobe  = 1'b0;
						case (fld[1][7:0])
							KEY_UP:     kb_joy[JOY_UP]    = fld[0][0];
							KEY_DOWN:   kb_joy[JOY_DOWN]  = fld[0][0];
							KEY_LEFT:   kb_joy[JOY_LEFT]  = fld[0][0];
							KEY_RIGHT:  kb_joy[JOY_RIGHT] = fld[0][0];
							KEY_FIRE1:  kb_joy[JOY_FIRE1] = fld[0][0];
							KEY_FIRE2:  kb_joy[JOY_FIRE2] = fld[0][0];
							KEY_START1: kb_start1         = fld[0][0];
							KEY_START2: kb_start2         = fld[0][0];
							default: ;
						endcase
					end
					"E": begin
						@(negedge clk_sys);
						check_value(32'(ip_1p), fld[0], "ip_1p");
						check_value(32'(ip_2p), fld[1], "ip_2p");
						check_value(32'(ip_coin1), fld[2], "ip_coin1");
					end
					"C": begin
						cfg_op     = shell_op_e'(fld[0][1:0]);
						cfg_data   = fld[1][7:0];
						cfg_strobe = 1'b1;
						@(negedge clk_sys);
						cfg_strobe = 1'b0;
						if (cfg_op == OP_SET_OPTIONS)
							opt_rotate = cfg_data[OPT_ROTATE];
						else if (cfg_op == OP_CLEAR_OPTIONS)
							opt_rotate = 1'b0;
						else if (cfg_op == OP_CORE_RESET)
							measure_reset_hold("a core reset command");
					end
					"J": begin
						for (i = 0; i < int'(fld[0]); i++) begin
							lcg_state  = lcg_next(lcg_state);
							joystick_0 = lcg_state[23:16];
							lcg_state  = lcg_next(lcg_state);
							joystick_1 = lcg_state[23:16];
							@(negedge clk_sys);
							check_value(32'(ip_1p),
								32'(expected_word(opt_rotate, kb_start1, kb_joy | joystick_0)),
								"ip_1p");
							check_value(32'(ip_2p),
								32'(expected_word(opt_rotate, kb_start2, joystick_1)), "ip_2p");
						end
					end
					"V": begin
						core_r  = fld[0][COLOR_BITS-1:0];
						core_g  = fld[1][COLOR_BITS-1:0];
						core_b  = fld[2][COLOR_BITS-1:0];
						core_hs = fld[3][0];
						core_vs = fld[4][0];
						core_hb = fld[5][0];
						core_vb = fld[6][0];
						@(negedge clk_sys);
						check_value(32'(vga_r), fld[7], "vga_r");
						check_value(32'(vga_g), fld[8], "vga_g");
						check_value(32'(vga_b), fld[9], "vga_b");
						check_value(32'(vga_hs), fld[10], "vga_hs");
						check_value(32'(vga_vs), fld[11], "vga_vs");
					end
					default: begin // Audio level held for one full window
						core_audio = fld[0][DAC_WIDTH-1:0];
						level      = int'(core_audio);
						ones       = 0;
						for (i = 0; i < (1 << DAC_WIDTH); i++) begin
							@(negedge clk_sys);
							check_value(32'(audio_r), 32'(audio_l), "audio_r");
							if (audio_l) ones++;
						end
						check_value(32'((ones >= level - 1 && ones <= level + 1) ? level : ones),
							32'(level), "audio_l ones per window");
					end
				endcase
			end
		end
		$fclose(fd);
		$display("Test completed successfully");
		$finish;
	end

endmodule

// ==== arcade_shell.f ====
common/shell_cfg_pkg.sv
common/video_pkg.sv
hdl/core_control.sv
hdl/clock_enables.sv
hdl/key_decoder.sv
hdl/control_mapper.sv
hdl/video_blanker.sv
hdl/sigma_delta_dac.sv
hdl/arcade_shell.sv
testbench/arcade_shell_checker.sv
testbench/arcade_shell_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile the arcade shell testbench with Verilator and run it from the project root
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert -f arcade_shell.f \
		--top-module arcade_shell_tb -o arcade_shell_sim \
	&& ./obj_dir/arcade_shell_sim \
	|| exit 1

// ==== testbench/arcade_shell_stim.txt ====
# Records: K pressed code | E ip_1p ip_2p ip_coin1 | C op data | J count of random pairs
# V r g b hs vs hb vb vga_r vga_g vga_b vga_hs vga_vs | A audio level, all fields hex
# Keyboard, press and release every cabinet key, then one unknown code
K 1 75  E 7D 7F 1
K 0 75  E 7F 7F 1
K 1 72  E 7E 7F 1
K 0 72  E 7F 7F 1
K 1 6B  E 77 7F 1
K 0 6B  E 7F 7F 1
K 1 74  E 7B 7F 1
K 0 74  E 7F 7F 1
K 1 29  E 6F 7F 1
K 0 29  E 7F 7F 1
K 1 11  E 5F 7F 1
K 0 11  E 7F 7F 1
K 1 05  E 3F 7F 1
K 0 05  E 7F 7F 1
K 1 06  E 7F 3F 1
K 0 06  E 7F 7F 1
K 1 76  E 7F 7F 0
K 0 76  E 7F 7F 1
K 1 1C  E 7F 7F 1
# Joysticks with up held on the keyboard, normal then rotated
K 1 75  E 7D 7F 1
J 10
C 1 01
J 10
C 2 00
# Video, blanking and sync inversion, then SCAN_50 and SCAN_75 lines
V F 8 3 0 0 0 0  F 8 3 1 1
V 9 A 5 0 0 1 0  0 0 0 1 1
V 9 A 5 1 1 0 1  0 0 0 0 0
C 1 04
V 9 A 5 0 0 0 0  9 A 5 1 1
V 9 A 5 1 0 0 0  4 5 2 0 1
V F 7 1 0 0 0 0  7 3 0 1 1
V F 7 1 1 0 0 0  F 7 1 0 1
V F 7 1 0 0 0 0  F 7 1 1 1
C 1 06
V F 8 6 1 0 0 0  3 2 1 0 1
V F 8 6 0 0 0 0  3 2 1 1 1
V C 4 7 0 1 0 1  0 0 0 1 0
V C 4 7 1 0 0 0  3 1 1 0 1
# Audio levels
A 000
A 001
A 200
A 3FF
A 155
A 2AB
